// File: compile.f
logic/offload_pkg.sv
logic/offload_req_stage.sv
logic/ssr_cfg_unit.sv
logic/offload_rsp_arbiter.sv
logic/mem_route.sv
logic/core_complex_fabric.sv
verification/core_complex_fabric_asserts.sv
verification/tb_core_complex_fabric.sv

// File: verification/tb_core_complex_fabric.sv
// -------------------------------------------------------------------
// Core complex fabric testbench
// Random offload and memory traffic against reference models
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_core_complex_fabric
  import offload_pkg::*;
();

  localparam int unsigned N_ACC          = 200;
  localparam int unsigned N_MEM          = 200;
  localparam int unsigned RST_CYCLES     = 8;
  localparam int unsigned TIMEOUT_CYCLES = 4 * (N_ACC + N_MEM) * 20;
  localparam addr_t       TCDM_BASE      = 32'h1002_0000;

  logic     clk_i, rst_ni;
  acc_req_t acc_req_i;
  logic     acc_valid_i, acc_ready_o;
  acc_rsp_t acc_rsp_o;
  logic     acc_rsp_valid_o, acc_rsp_ready_i;
  acc_req_t fpu_req_o, hive_req_o;
  logic     fpu_valid_o, fpu_ready_i, hive_valid_o, hive_ready_i;
  acc_rsp_t fpu_rsp_i, hive_rsp_i;
  logic     fpu_rsp_valid_i, fpu_rsp_ready_o, hive_rsp_valid_i, hive_rsp_ready_o;
  addr_t    tcdm_base_i;
  mem_req_t core_req_i, tcdm_req_o, soc_req_o;
  logic     core_valid_i, core_ready_o, core_rsp_valid_o;
  mem_rsp_t core_rsp_o, tcdm_rsp_i, soc_rsp_i;
  logic     tcdm_valid_o, tcdm_ready_i, tcdm_rsp_valid_i, tcdm_rsp_ready_o;
  logic     soc_valid_o, soc_ready_i, soc_rsp_valid_i, soc_rsp_ready_o;

  logic [31:0] lfsr_q;
  logic        run, post_rst;
  logic        acc_hs, mem_hs, fpu_rsp_hs, hive_rsp_hs, tcdm_rsp_hs, soc_rsp_hs;
  int unsigned acc_built, mem_built, acc_rsp_cnt, mem_rsp_cnt, rst_cnt, mem_out;
  int unsigned check_cnt, err_cnt;
  acc_req_t    fpu_exp_q[$], hive_exp_q[$], ssr_req_q[$];
  acc_rsp_t    fpu_pend[$], hive_pend[$], ssr_rsp_exp[$], core_exp_q[$];
  mem_rsp_t    tcdm_pend[$], soc_pend[$], mem_exp_q[$];
  data_t       ssr_m [NUM_SSRS][NUM_SSR_REGS];

  core_complex_fabric dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // -------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [159:0] exp, input logic [159:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("error: %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  function automatic acc_req_t make_offload();
    acc_req_t    r;
    logic [31:0] rg, dm, kind;
    logic [11:0] a;
    r.target    = acc_target_t'(rand_bits(2) % 3);
    r.id        = acc_id_t'(rand_bits(5));
    r.data_op   = rand_bits(32);
    r.data_arga = rand_bits(32);
    r.data_argb = rand_bits(32);
    r.data_argc = rand_bits(32);
    if (r.target == TARGET_SSR) begin
      kind = rand_bits(3);
      rg   = rand_bits(4);
      dm   = rand_bits(2);
      // Register index in 11..5 over data mover in 4..0, some out of range
      a    = {rg[6:0], dm[4:0]};
      case (kind)
        0:       r.data_op = {a, r.data_op[19:0]} & ~SCFG_MASK | SCFGRI_MATCH;
        1, 4, 5: r.data_op = {a, r.data_op[19:0]} & ~SCFG_MASK | SCFGWI_MATCH;
        2, 6:    r.data_op = r.data_op & ~SCFG_MASK | SCFGR_MATCH;
        3:       r.data_op = r.data_op & ~SCFG_MASK | SCFGW_MATCH;
        default: r.data_op = r.data_op & ~SCFG_MASK | 32'h0000_0033;
      endcase
      r.data_argb = {r.data_argb[31:12], a};
    end
    return r;
  endfunction

  // Reference SSR register file updated in issue order
  function automatic acc_rsp_t ssr_model(input acc_req_t r);
    acc_rsp_t    rsp;
    logic [31:0] f;
    logic [11:0] a;
    logic        wr, ok;
    data_t       prev;
    f  = r.data_op & SCFG_MASK;
    wr = (f == SCFGWI_MATCH) || (f == SCFGW_MATCH);
    if (f == SCFGRI_MATCH || f == SCFGWI_MATCH) begin
      a = r.data_op[31:20];
    end else if (f == SCFGR_MATCH || f == SCFGW_MATCH) begin
      a = r.data_argb[11:0];
    end else begin
      a = '0;
    end
    ok   = (a[4:0] < NUM_SSRS) && (a[11:5] < NUM_SSR_REGS);
    prev = ok ? ssr_m[a[4:0]][a[11:5]] : '0;
    if (wr && ok) begin
      ssr_m[a[4:0]][a[11:5]] = r.data_arga;
    end
    rsp.id    = wr ? acc_id_t'(0) : r.id;
    rsp.data  = prev;
    rsp.error = 1'b0;
    return rsp;
  endfunction

  // Response of an external unit model
  function automatic acc_rsp_t ext_rsp(input acc_id_t id, input data_t data);
    acc_rsp_t rsp;
    rsp.id    = id;
    rsp.data  = data;
    rsp.error = 1'b0;
    return rsp;
  endfunction

  // Port memory models derive rdata from the address
  function automatic mem_rsp_t port_rsp(input addr_t addr, input logic tcdm);
    mem_rsp_t m;
    m.rdata = tcdm ? ~addr : addr ^ 32'h3c3c_5a5a;
    m.error = tcdm ? 1'b0 : addr[2];
    return m;
  endfunction

  // -------------------------------------------------------------------
  // Monitor at the rising edge
  // -------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic     is_t;
    mem_rsp_t mrsp;
    acc_req_t exp_req;
    acc_hs      = 1'b0;
    mem_hs      = 1'b0;
    fpu_rsp_hs  = 1'b0;
    hive_rsp_hs = 1'b0;
    tcdm_rsp_hs = 1'b0;
    soc_rsp_hs  = 1'b0;
    if (rst_ni || post_rst) begin
      if (rst_cnt > 0) begin
        check("reset valids", 6'b0, {fpu_valid_o, hive_valid_o, acc_rsp_valid_o,
                                     tcdm_valid_o, soc_valid_o, core_rsp_valid_o});
      end
      rst_cnt++;
      post_rst = rst_ni;
    end else begin
      // Core side response before the sources feeding the arbiter
      if (acc_rsp_valid_o && acc_rsp_ready_i) begin
        if (core_exp_q.size() == 0) begin
          err_cnt++;
          $display("Offload response arrived with none outstanding");
        end else begin
          check("offload response", core_exp_q.pop_front(), acc_rsp_o);
        end
        acc_rsp_cnt++;
      end
      fpu_rsp_hs  = fpu_rsp_valid_i && fpu_rsp_ready_o;
      hive_rsp_hs = hive_rsp_valid_i && hive_rsp_ready_o;
      if (fpu_rsp_hs) core_exp_q.push_back(fpu_pend.pop_front());
      if (hive_rsp_hs) core_exp_q.push_back(hive_pend.pop_front());
      if (dut_i.ssr_rsp_valid && dut_i.src_ready[TARGET_SSR]) begin
        core_exp_q.push_back(ssr_rsp_exp.pop_front());
      end
      // Target request ports
      if (fpu_valid_o && fpu_ready_i) begin
        exp_req = fpu_exp_q.pop_front();
        check("fpu request", exp_req, fpu_req_o);
        fpu_pend.push_back(ext_rsp(exp_req.id, exp_req.data_arga + 32'd1));
      end
      if (hive_valid_o && hive_ready_i) begin
        exp_req = hive_exp_q.pop_front();
        check("hive request", exp_req, hive_req_o);
        hive_pend.push_back(ext_rsp(exp_req.id, exp_req.data_argb ^ 32'hc3c3_0f0f));
      end
      if (dut_i.tgt_valid[TARGET_SSR] && dut_i.tgt_ready[TARGET_SSR]) begin
        check("ssr request", ssr_req_q.pop_front(), dut_i.tgt_req);
      end
      acc_hs = acc_valid_i && acc_ready_o;
      if (acc_hs) begin
        case (acc_req_i.target)
          TARGET_HIVE: hive_exp_q.push_back(acc_req_i);
          TARGET_SSR: begin
            ssr_req_q.push_back(acc_req_i);
            ssr_rsp_exp.push_back(ssr_model(acc_req_i));
          end
          default: fpu_exp_q.push_back(acc_req_i);
        endcase
      end
      // Memory route
      if (core_rsp_valid_o) begin
        if (mem_exp_q.size() == 0) begin
          err_cnt++;
          $display("Memory response arrived with no request outstanding");
        end else begin
          check("memory response", mem_exp_q.pop_front(), core_rsp_o);
        end
        mem_rsp_cnt++;
        mem_out--;
      end
      tcdm_rsp_hs = tcdm_rsp_valid_i && tcdm_rsp_ready_o;
      soc_rsp_hs  = soc_rsp_valid_i && soc_rsp_ready_o;
      if (tcdm_rsp_hs) void'(tcdm_pend.pop_front());
      if (soc_rsp_hs) void'(soc_pend.pop_front());
      mem_hs = core_valid_i && core_ready_o;
      if (mem_hs) begin
        // TCDM window is every address sharing the base bits above the TCDM range
        is_t = core_req_i.addr[31:TCDM_ADDR_WIDTH] == TCDM_BASE[31:TCDM_ADDR_WIDTH];
        check("memory port select", {is_t, !is_t}, {tcdm_valid_o, soc_valid_o});
        check("memory payload", core_req_i, is_t ? tcdm_req_o : soc_req_o);
        mrsp = port_rsp(core_req_i.addr, is_t);
        mem_exp_q.push_back(mrsp);
        if (is_t) tcdm_pend.push_back(mrsp);
        else soc_pend.push_back(mrsp);
        mem_out++;
      end
      if (mem_out > MEM_RSP_DEPTH) begin
        err_cnt++;
        $display("More than %0d memory requests outstanding", MEM_RSP_DEPTH);
      end
    end
  end

  // -------------------------------------------------------------------
  // Stimulus and responders at the falling edge
  // -------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (run) begin
      if (acc_valid_i && acc_hs) acc_valid_i = 1'b0;
      if (!acc_valid_i && acc_built < N_ACC && rand_bits(1)) begin
        acc_req_i   = make_offload();
        acc_valid_i = 1'b1;
        acc_built++;
      end
      if (core_valid_i && mem_hs) core_valid_i = 1'b0;
      if (!core_valid_i && mem_built < N_MEM && rand_bits(1)) begin
        core_req_i.addr  = rand_bits(1) ? (TCDM_BASE | rand_bits(TCDM_ADDR_WIDTH)) : rand_bits(32);
        core_req_i.wdata = rand_bits(32);
        core_req_i.write = rand_bits(1);
        core_req_i.strb  = strb_t'(rand_bits(4));
        core_valid_i     = 1'b1;
        mem_built++;
      end
      fpu_ready_i     = rand_bits(2) != 0;
      hive_ready_i    = rand_bits(2) != 0;
      acc_rsp_ready_i = rand_bits(2) != 0;
      tcdm_ready_i    = rand_bits(2) != 0;
      soc_ready_i     = rand_bits(2) != 0;
      // Responders hold the front entry until it is taken
      if (fpu_rsp_hs) fpu_rsp_valid_i = 1'b0;
      if (!fpu_rsp_valid_i && fpu_pend.size() > 0 && rand_bits(1)) begin
        fpu_rsp_i       = fpu_pend[0];
        fpu_rsp_valid_i = 1'b1;
      end
      if (hive_rsp_hs) hive_rsp_valid_i = 1'b0;
      if (!hive_rsp_valid_i && hive_pend.size() > 0 && rand_bits(1)) begin
        hive_rsp_i       = hive_pend[0];
        hive_rsp_valid_i = 1'b1;
      end
      if (tcdm_rsp_hs) tcdm_rsp_valid_i = 1'b0;
      if (!tcdm_rsp_valid_i && tcdm_pend.size() > 0 && rand_bits(1)) begin
        tcdm_rsp_i       = tcdm_pend[0];
        tcdm_rsp_valid_i = 1'b1;
      end
      if (soc_rsp_hs) soc_rsp_valid_i = 1'b0;
      if (!soc_rsp_valid_i && soc_pend.size() > 0 && rand_bits(1)) begin
        soc_rsp_i       = soc_pend[0];
        soc_rsp_valid_i = 1'b1;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Watchdog expired before all transactions completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    lfsr_q = 32'haa09;
    {run, post_rst, acc_valid_i, acc_rsp_ready_i, fpu_ready_i, hive_ready_i} = '0;
    {fpu_rsp_valid_i, hive_rsp_valid_i, core_valid_i, tcdm_ready_i, soc_ready_i} = '0;
    {tcdm_rsp_valid_i, soc_rsp_valid_i} = '0;
    {acc_req_i, fpu_rsp_i, hive_rsp_i, core_req_i, tcdm_rsp_i, soc_rsp_i} = '0;
    {acc_built, mem_built, acc_rsp_cnt, mem_rsp_cnt, rst_cnt, mem_out} = '0;
    {check_cnt, err_cnt} = '0;
    for (int d = 0; d < NUM_SSRS; d++) begin
      for (int r = 0; r < NUM_SSR_REGS; r++) ssr_m[d][r] = '0;
    end
    tcdm_base_i = TCDM_BASE;
    rst_ni      = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    run = 1'b1;
    wait (acc_rsp_cnt == N_ACC && mem_rsp_cnt == N_MEM);
    repeat (10) @(posedge clk_i);
    if (core_exp_q.size() + fpu_exp_q.size() + hive_exp_q.size() + ssr_req_q.size() +
        mem_exp_q.size() != 0) begin
      err_cnt++;
      $display("Transactions left over after the last response");
    end
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/core_complex_fabric_asserts.sv
// -------------------------------------------------------------------
// Fabric assertions
// Grant, handshake and reset properties on the arbiter and memory route
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_complex_fabric_asserts (
  input logic       clk_i,
  input logic       rst_ni,
  input logic [2:0] gnt_i,
  input logic       out_valid_i,
  input logic       out_ready_i,
  input logic       fifo_empty_i,
  input logic       rsp_valid_i
);

  grant_onehot: assert property (@(posedge clk_i) disable iff (rst_ni) $onehot0(gnt_i))
    else $error("More than one source granted at once");

  // Valid may not drop before the transfer
  valid_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
    out_valid_i && !out_ready_i |=> out_valid_i)
    else $error("Valid dropped while stalled");

  no_rsp_when_empty: assert property (@(posedge clk_i) disable iff (rst_ni)
    fifo_empty_i |-> !rsp_valid_i)
    else $error("Response passed with no request outstanding");

  reset_low: assert property (@(posedge clk_i) rst_ni |=> !out_valid_i && !rsp_valid_i)
    else $error("Valid high during reset");

endmodule

bind offload_rsp_arbiter core_complex_fabric_asserts arb_asserts_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .gnt_i(src_ready_o), .out_valid_i(rsp_valid_o),
  .out_ready_i(rsp_ready_i), .fifo_empty_i(~|src_valid_i), .rsp_valid_i(|src_ready_o)
);

bind mem_route core_complex_fabric_asserts route_asserts_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .gnt_i({1'b0, tcdm_valid_o, soc_valid_o}),
  .out_valid_i(tcdm_valid_o | soc_valid_o), .out_ready_i(core_ready_o),
  .fifo_empty_i(fifo_empty), .rsp_valid_i(core_rsp_valid_o)
);

`default_nettype wire

// File: logic/core_complex_fabric.sv
// -------------------------------------------------------------------
// Core complex fabric top level
// Offload request routing, SSR configuration, response arbitration
// and the data memory route
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_complex_fabric
  import offload_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Offload from the core
  input  acc_req_t acc_req_i,
  input  logic     acc_valid_i,
  output logic     acc_ready_o,
  output acc_rsp_t acc_rsp_o,
  output logic     acc_rsp_valid_o,
  input  logic     acc_rsp_ready_i,
  // External FPU
  output acc_req_t fpu_req_o,
  output logic     fpu_valid_o,
  input  logic     fpu_ready_i,
  input  acc_rsp_t fpu_rsp_i,
  input  logic     fpu_rsp_valid_i,
  output logic     fpu_rsp_ready_o,
  // Shared muldiv
  output acc_req_t hive_req_o,
  output logic     hive_valid_o,
  input  logic     hive_ready_i,
  input  acc_rsp_t hive_rsp_i,
  input  logic     hive_rsp_valid_i,
  output logic     hive_rsp_ready_o,
  // Data memory
  input  addr_t    tcdm_base_i,
  input  mem_req_t core_req_i,
  input  logic     core_valid_i,
  output logic     core_ready_o,
  output mem_rsp_t core_rsp_o,
  output logic     core_rsp_valid_o,
  output mem_req_t tcdm_req_o,
  output logic     tcdm_valid_o,
  input  logic     tcdm_ready_i,
  input  mem_rsp_t tcdm_rsp_i,
  input  logic     tcdm_rsp_valid_i,
  output logic     tcdm_rsp_ready_o,
  output mem_req_t soc_req_o,
  output logic     soc_valid_o,
  input  logic     soc_ready_i,
  input  mem_rsp_t soc_rsp_i,
  input  logic     soc_rsp_valid_i,
  output logic     soc_rsp_ready_o
);

  acc_req_t                   tgt_req;
  logic     [NUM_TARGETS-1:0] tgt_valid, tgt_ready;
  acc_rsp_t                   ssr_rsp;
  logic                       ssr_rsp_valid;
  acc_rsp_t [NUM_TARGETS-1:0] src_rsp;
  logic     [NUM_TARGETS-1:0] src_valid, src_ready;

  // -----------------------------------------------------------------
  // Offload request path
  // -----------------------------------------------------------------
  offload_req_stage i_offload_req_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_req_i   (acc_req_i),
    .acc_valid_i (acc_valid_i),
    .acc_ready_o (acc_ready_o),
    .tgt_req_o   (tgt_req),
    .tgt_valid_o (tgt_valid),
    .tgt_ready_i (tgt_ready)
  );

  // Shared request bus, one valid per target
  assign fpu_req_o    = tgt_req;
  assign hive_req_o   = tgt_req;
  assign fpu_valid_o  = tgt_valid[TARGET_FPU];
  assign hive_valid_o = tgt_valid[TARGET_HIVE];
  assign tgt_ready[TARGET_FPU]  = fpu_ready_i;
  assign tgt_ready[TARGET_HIVE] = hive_ready_i;

  ssr_cfg_unit i_ssr_cfg_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (tgt_req),
    .valid_i     (tgt_valid[TARGET_SSR]),
    .ready_o     (tgt_ready[TARGET_SSR]),
    .rsp_o       (ssr_rsp),
    .rsp_valid_o (ssr_rsp_valid),
    .rsp_ready_i (src_ready[TARGET_SSR])
  );

  // -----------------------------------------------------------------
  // Offload response path
  // -----------------------------------------------------------------
  assign src_rsp   = {ssr_rsp, hive_rsp_i, fpu_rsp_i};
  assign src_valid = {ssr_rsp_valid, hive_rsp_valid_i, fpu_rsp_valid_i};
  assign fpu_rsp_ready_o  = src_ready[TARGET_FPU];
  assign hive_rsp_ready_o = src_ready[TARGET_HIVE];

  offload_rsp_arbiter i_offload_rsp_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .src_rsp_i   (src_rsp),
    .src_valid_i (src_valid),
    .src_ready_o (src_ready),
    .rsp_o       (acc_rsp_o),
    .rsp_valid_o (acc_rsp_valid_o),
    .rsp_ready_i (acc_rsp_ready_i)
  );

  // -----------------------------------------------------------------
  // Data memory route
  // -----------------------------------------------------------------
  mem_route i_mem_route (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tcdm_base_i      (tcdm_base_i),
    .core_req_i       (core_req_i),
    .core_valid_i     (core_valid_i),
    .core_ready_o     (core_ready_o),
    .core_rsp_o       (core_rsp_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .tcdm_req_o       (tcdm_req_o),
    .tcdm_valid_o     (tcdm_valid_o),
    .tcdm_ready_i     (tcdm_ready_i),
    .tcdm_rsp_i       (tcdm_rsp_i),
    .tcdm_rsp_valid_i (tcdm_rsp_valid_i),
    .tcdm_rsp_ready_o (tcdm_rsp_ready_o),
    .soc_req_o        (soc_req_o),
    .soc_valid_o      (soc_valid_o),
    .soc_ready_i      (soc_ready_i),
    .soc_rsp_i        (soc_rsp_i),
    .soc_rsp_valid_i  (soc_rsp_valid_i),
    .soc_rsp_ready_o  (soc_rsp_ready_o)
  );

endmodule

`default_nettype wire

// File: logic/mem_route.sv
// -------------------------------------------------------------------
// Memory route
// Splits core data requests between TCDM and SoC by base/mask and
// returns the responses in request order
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_route
  import offload_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  addr_t    tcdm_base_i,
  // Core side
  input  mem_req_t core_req_i,
  input  logic     core_valid_i,
  output logic     core_ready_o,
  output mem_rsp_t core_rsp_o,
  output logic     core_rsp_valid_o,
  // TCDM port
  output mem_req_t tcdm_req_o,
  output logic     tcdm_valid_o,
  input  logic     tcdm_ready_i,
  input  mem_rsp_t tcdm_rsp_i,
  input  logic     tcdm_rsp_valid_i,
  output logic     tcdm_rsp_ready_o,
  // SoC port
  output mem_req_t soc_req_o,
  output logic     soc_valid_o,
  input  logic     soc_ready_i,
  input  mem_rsp_t soc_rsp_i,
  input  logic     soc_rsp_valid_i,
  output logic     soc_rsp_ready_o
);

  mem_port_t            fifo_q [MEM_RSP_DEPTH];
  logic [MEM_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [MEM_PTR_W:0]   count_q;
  logic                 fifo_full, fifo_empty;
  logic                 is_tcdm;
  logic                 push, pop;
  mem_port_t            head_port;

  // ---------------------------------------------------------------
  // Request side
  // ---------------------------------------------------------------
  assign is_tcdm = (core_req_i.addr & TCDM_MASK) == (tcdm_base_i & TCDM_MASK);

  assign tcdm_req_o   = core_req_i;
  assign soc_req_o    = core_req_i;
  assign tcdm_valid_o = core_valid_i & ~fifo_full & is_tcdm;
  assign soc_valid_o  = core_valid_i & ~fifo_full & ~is_tcdm;
  assign core_ready_o = ~fifo_full & (is_tcdm ? tcdm_ready_i : soc_ready_i);
  assign push         = core_valid_i & core_ready_o;

  // ---------------------------------------------------------------
  // Route FIFO and response side
  // ---------------------------------------------------------------
  assign fifo_full  = count_q == (MEM_PTR_W + 1)'(MEM_RSP_DEPTH);
  assign fifo_empty = count_q == '0;
  assign head_port  = fifo_q[rd_ptr_q];

  // Only the port at the head may answer
  assign tcdm_rsp_ready_o = ~fifo_empty & (head_port == MEM_TCDM);
  assign soc_rsp_ready_o  = ~fifo_empty & (head_port == MEM_SOC);
  assign core_rsp_valid_o = (tcdm_rsp_valid_i & tcdm_rsp_ready_o) |
                            (soc_rsp_valid_i & soc_rsp_ready_o);
  assign core_rsp_o       = (head_port == MEM_TCDM) ? tcdm_rsp_i : soc_rsp_i;
  assign pop              = core_rsp_valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= is_tcdm ? MEM_TCDM : MEM_SOC;
    end
  end

endmodule

`default_nettype wire

// File: logic/offload_rsp_arbiter.sv
// -------------------------------------------------------------------
// Offload response arbiter
// Round-robin over the FPU, HIVE and SSR responses into one
// registered response towards the core
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module offload_rsp_arbiter
  import offload_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  acc_rsp_t [NUM_TARGETS-1:0]        src_rsp_i,
  input  logic     [NUM_TARGETS-1:0]        src_valid_i,
  output logic     [NUM_TARGETS-1:0]        src_ready_o,
  output acc_rsp_t                          rsp_o,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i
);

  acc_rsp_t               rsp_q;
  logic                   rsp_valid_q;
  logic [TGT_IDX_W-1:0]   last_q, gnt_idx;
  logic [NUM_TARGETS-1:0] gnt;
  logic                   any_gnt;
  logic                   load_en;

  // Output slot takes a new item when empty or draining
  assign load_en = ~rsp_valid_q | rsp_ready_i;

  // Search starts one past the last granted source
  always_comb begin
    int unsigned idx;
    gnt     = '0;
    gnt_idx = last_q;
    any_gnt = 1'b0;
    for (int unsigned k = 1; k <= NUM_TARGETS; k++) begin
      idx = (last_q + k) % NUM_TARGETS;
      if (!any_gnt && src_valid_i[idx]) begin
        any_gnt  = 1'b1;
        gnt_idx  = idx[TGT_IDX_W-1:0];
        gnt[idx] = 1'b1;
      end
    end
  end

  assign src_ready_o = gnt & {NUM_TARGETS{load_en}};

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_valid_q <= 1'b0;
      last_q      <= TGT_IDX_W'(NUM_TARGETS - 1);
    end else if (load_en) begin
      rsp_valid_q <= any_gnt;
      if (any_gnt) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && any_gnt) begin
      rsp_q <= src_rsp_i[gnt_idx];
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

// File: logic/ssr_cfg_unit.sv
// -------------------------------------------------------------------
// SSR configuration unit
// Decodes the SCFG read/write instructions and serves them from the
// 3 x 8 word configuration register file
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ssr_cfg_unit
  import offload_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  acc_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output acc_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  data_t       cfg_q [NUM_SSRS][NUM_SSR_REGS];
  acc_rsp_t    rsp_q;
  logic        rsp_valid_q;
  logic        is_rd_imm, is_wr_imm, is_rd_reg, is_wr_reg;
  logic        is_write;
  logic [11:0] cfg_addr;
  ssr_word_t   cfg_word;
  logic [4:0]  word_dm;
  logic [6:0]  word_reg;
  logic        in_range;
  data_t       rdata;
  logic        req_hs;

  // ---------------------------------------------------------------
  // Instruction decode
  // ---------------------------------------------------------------
  assign is_rd_imm = (req_i.data_op & SCFG_MASK) == SCFGRI_MATCH;
  assign is_wr_imm = (req_i.data_op & SCFG_MASK) == SCFGWI_MATCH;
  assign is_rd_reg = (req_i.data_op & SCFG_MASK) == SCFGR_MATCH;
  assign is_wr_reg = (req_i.data_op & SCFG_MASK) == SCFGW_MATCH;
  assign is_write  = is_wr_imm | is_wr_reg;

  // Unknown ops fall back to a read of word zero
  always_comb begin
    if (is_rd_imm || is_wr_imm) begin
      cfg_addr = req_i.data_op[31:20];
    end else if (is_rd_reg || is_wr_reg) begin
      cfg_addr = req_i.data_argb[11:0];
    end else begin
      cfg_addr = '0;
    end
  end

  // Register index sits above the data mover index in the address
  assign cfg_word = {cfg_addr[4:0], cfg_addr[11:5]};
  assign word_dm  = cfg_word[11:7];
  assign word_reg = cfg_word[6:0];
  assign in_range = (word_dm < NUM_SSRS) && (word_reg < NUM_SSR_REGS);

  assign rdata = in_range ?
      cfg_q[word_dm[SSR_DM_SEL_W-1:0]][word_reg[SSR_REG_SEL_W-1:0]] : '0;

  // ---------------------------------------------------------------
  // Register file and response slot
  // ---------------------------------------------------------------
  assign ready_o = ~rsp_valid_q | rsp_ready_i;
  assign req_hs  = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      for (int unsigned d = 0; d < NUM_SSRS; d++) begin
        for (int unsigned r = 0; r < NUM_SSR_REGS; r++) begin
          cfg_q[d][r] <= '0;
        end
      end
    end else if (req_hs && is_write && in_range) begin
      cfg_q[word_dm[SSR_DM_SEL_W-1:0]][word_reg[SSR_REG_SEL_W-1:0]] <=
          req_i.data_arga[31:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (req_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Writes answer with id 0 so the core skips the write-back
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_q.id    <= is_write ? acc_id_t'(0) : req_i.id;
      rsp_q.data  <= rdata;
      rsp_q.error <= 1'b0;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

// File: logic/offload_req_stage.sv
// -------------------------------------------------------------------
// Offload request stage
// Two-entry spill register on the offload request, steered by the
// target field of the outgoing entry
// -------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module offload_req_stage
  import offload_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  acc_req_t               acc_req_i,
  input  logic                   acc_valid_i,
  output logic                   acc_ready_o,
  output acc_req_t               tgt_req_o,
  output logic [NUM_TARGETS-1:0] tgt_valid_o,
  input  logic [NUM_TARGETS-1:0] tgt_ready_i
);

  acc_req_t             a_data_q, b_data_q;
  logic                 a_full_q, b_full_q;
  logic                 a_fill, a_drain, b_fill, b_drain;
  logic                 out_valid, out_ready;
  logic [TGT_IDX_W-1:0] tgt_idx;

  // Entry A takes new requests, entry B catches one under a stall
  assign acc_ready_o = ~a_full_q | ~b_full_q;
  assign a_fill      = acc_valid_i & acc_ready_o;
  assign a_drain     = a_full_q & ~b_full_q;
  assign b_fill      = a_drain & ~out_ready;
  assign b_drain     = b_full_q & out_ready;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= acc_req_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older entry leaves first
  assign out_valid = a_full_q | b_full_q;
  assign tgt_req_o = b_full_q ? b_data_q : a_data_q;

  // Target decode, unused code goes to the FPU
  always_comb begin
    case (tgt_req_o.target)
      TARGET_HIVE: tgt_idx = TGT_IDX_W'(1);
      TARGET_SSR:  tgt_idx = TGT_IDX_W'(2);
      default:     tgt_idx = TGT_IDX_W'(0);
    endcase
  end

  always_comb begin
    for (int unsigned i = 0; i < NUM_TARGETS; i++) begin
      tgt_valid_o[i] = out_valid && (tgt_idx == i);
    end
  end

  assign out_ready = tgt_ready_i[tgt_idx];

endmodule

`default_nettype wire

// File: logic/offload_pkg.sv
// -------------------------------------------------------------------
// Offload fabric package
// Widths, target codes, SSR config opcodes and the bus structs shared
// by the offload path and the memory route
// -------------------------------------------------------------------

`default_nettype none

package offload_pkg;

  // Meaningful widths
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  acc_id_t;
  typedef logic [1:0]  acc_target_t;
  typedef logic [3:0]  strb_t;
  // Data mover index (5 bits) followed by register index (7 bits)
  typedef logic [11:0] ssr_word_t;

  // Offload targets, code 3 falls back to the FPU
  localparam acc_target_t TARGET_FPU  = 2'd0;
  localparam acc_target_t TARGET_HIVE = 2'd1;
  localparam acc_target_t TARGET_SSR  = 2'd2;
  localparam int unsigned NUM_TARGETS = 3;
  localparam int unsigned TGT_IDX_W   = $clog2(NUM_TARGETS);

  // SSR configuration space
  localparam int unsigned NUM_SSRS      = 3;
  localparam int unsigned NUM_SSR_REGS  = 8;
  localparam int unsigned SSR_DM_SEL_W  = $clog2(NUM_SSRS);
  localparam int unsigned SSR_REG_SEL_W = $clog2(NUM_SSR_REGS);

  // Custom-1 opcode, funct3 picks the config instruction
  localparam logic [31:0] SCFG_MASK    = 32'h0000_707f;
  localparam logic [31:0] SCFGRI_MATCH = 32'h0000_102b;
  localparam logic [31:0] SCFGWI_MATCH = 32'h0000_202b;
  localparam logic [31:0] SCFGR_MATCH  = 32'h0000_502b;
  localparam logic [31:0] SCFGW_MATCH  = 32'h0000_602b;

  // Memory routing
  localparam int unsigned TCDM_ADDR_WIDTH = 17;
  localparam addr_t       TCDM_MASK       = {32{1'b1}} << TCDM_ADDR_WIDTH;
  localparam int unsigned MEM_RSP_DEPTH   = 4;
  localparam int unsigned MEM_PTR_W       = $clog2(MEM_RSP_DEPTH);

  typedef struct packed {
    acc_target_t target;
    acc_id_t     id;
    data_t       data_op;
    data_t       data_arga;
    data_t       data_argb;
    data_t       data_argc;
  } acc_req_t;

  typedef struct packed {
    acc_id_t id;
    data_t   data;
    logic    error;
  } acc_rsp_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  write;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } mem_rsp_t;

  typedef enum logic {
    MEM_SOC  = 1'b0,
    MEM_TCDM = 1'b1
  } mem_port_t;

endpackage

`default_nettype wire
